/* filelist.f */
hdl/vcache_pkg.sv
hdl/vcache_tile.sv
hdl/vcache_dma_arbiter.sv
hdl/vcache_array.sv
tests/vcache_mem_responder.sv
tests/vcache_array_tb.sv

/* Bender.yml */
package:
  name: vcache_array

sources:
  - target: rtl
    files:
      - hdl/vcache_pkg.sv
      - hdl/vcache_tile.sv
      - hdl/vcache_dma_arbiter.sv
      - hdl/vcache_array.sv
  - target: test
    files:
      - tests/vcache_mem_responder.sv
      - tests/vcache_array_tb.sv

/* tests/vcache_array_tb.sv */
module vcache_array_tb
  import vcache_pkg::*;
;

  localparam int N_OPS = 200;
  localparam int TIMEOUT = 2 * N_OPS * 40;
  localparam logic [31:0] SEED = 32'h2eb4_785f;
  localparam logic [X_W-1:0] BASE_X = 4'd5;

  logic clk;
  logic arst_n;
  logic [X_W-1:0] global_x_in;
  logic [X_W-1:0] global_x_out;

  logic [1:0]             req;
  logic [1:0]             op_sel;
  logic [1:0][ADDR_W-1:0] addr;
  logic [1:0][DATA_W-1:0] wdata;
  logic [1:0]             ack;
  logic [1:0][DATA_W-1:0] rdata;

  logic              mem_req;
  vcache_op_e        mem_op;
  logic [ADDR_W-1:0] mem_addr;
  logic [DATA_W-1:0] mem_wdata;
  logic [X_W-1:0]    mem_src;
  logic              mem_ack;
  logic [DATA_W-1:0] mem_rdata;
  logic [1:0]        mem_delay;
  int                mem_errs;

  // reference model of memory and both tiles
  logic [DATA_W-1:0] mmem   [2**ADDR_W];
  logic              mvalid [2][SETS];
  logic [TAG_W-1:0]  mtag   [2][SETS];
  logic [DATA_W-1:0] mdata  [2][SETS];

  // stores in flight and the values an open load miss may legally return
  logic              st_pend [2];
  logic [ADDR_W-1:0] st_addr [2];
  logic [DATA_W-1:0] st_data [2];
  logic              ld_open [2];
  logic [ADDR_W-1:0] ld_addr [2];
  logic [DATA_W-1:0] ok_vals [2][4];
  int                ok_n    [2];

  logic [31:0] lfsr_s [3];
  int          data_errs;
  int          proto_errs;
  int          cycles;
  logic        timed_out;

  vcache_array i_vcache_array (
    .clk_i(clk)
    ,.arst_n_i(arst_n)
    ,.global_x_i(global_x_in)
    ,.global_x_o(global_x_out)
    ,.c0_req_i(req[0])
    ,.c0_op_i(vcache_op_e'(op_sel[0]))
    ,.c0_addr_i(addr[0])
    ,.c0_wdata_i(wdata[0])
    ,.c0_ack_o(ack[0])
    ,.c0_rdata_o(rdata[0])
    ,.c1_req_i(req[1])
    ,.c1_op_i(vcache_op_e'(op_sel[1]))
    ,.c1_addr_i(addr[1])
    ,.c1_wdata_i(wdata[1])
    ,.c1_ack_o(ack[1])
    ,.c1_rdata_o(rdata[1])
    ,.mem_req_o(mem_req)
    ,.mem_op_o(mem_op)
    ,.mem_addr_o(mem_addr)
    ,.mem_wdata_o(mem_wdata)
    ,.mem_src_o(mem_src)
    ,.mem_ack_i(mem_ack)
    ,.mem_rdata_i(mem_rdata)
  );

  vcache_mem_responder i_mem_responder (
    .clk_i(clk)
    ,.mem_req_i(mem_req)
    ,.mem_op_i(mem_op)
    ,.mem_addr_i(mem_addr)
    ,.mem_wdata_i(mem_wdata)
    ,.mem_src_i(mem_src)
    ,.delay_i(mem_delay)
    ,.mem_ack_o(mem_ack)
    ,.mem_rdata_o(mem_rdata)
    ,.error_cnt_o(mem_errs)
  );

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int stream, input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_s[stream] = lfsr_step(lfsr_s[stream]);
      v = {v[30:0], lfsr_s[stream][0]};
    end
    return v;
  endfunction

  function automatic void add_ok(input int p, input logic [DATA_W-1:0] v);
    if (ok_n[p] < 4) begin
      ok_vals[p][ok_n[p]] = v;
      ok_n[p]++;
    end
  endfunction

  function automatic logic is_ok(input int p, input logic [DATA_W-1:0] v);
    logic found;
    found = 1'b0;
    for (int k = 0; k < ok_n[p]; k++) begin
      if (ok_vals[p][k] == v) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  task automatic report();
    $display("errors: data %0d, protocol %0d, memory side %0d, timeout %0d",
             data_errs, proto_errs, mem_errs, timed_out);
    if (data_errs == 0 && proto_errs == 0 && mem_errs == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  task automatic run_port(input int p);
    int                 q;
    int                 gap;
    int                 hold;
    int                 cyc;
    int                 n0;
    int                 dn;
    logic [X_W-1:0]     src;
    vcache_op_e         o;
    logic [ADDR_W-1:0]  a;
    logic [DATA_W-1:0]  d;
    logic [DATA_W-1:0]  got;
    logic [INDEX_W-1:0] ix;
    logic               hit;
    logic               stored;
    q   = 1 - p;
    src = (p == 0) ? BASE_X : BASE_X + 1'b1;
    for (int i = 0; i < N_OPS; i++) begin
      o    = (take_bits(p, 2) == 0) ? OP_STORE : OP_LOAD;
      // 32 addresses over 8 sets gives both hits and conflicts
      a    = ADDR_W'(take_bits(p, 5));
      d    = DATA_W'(take_bits(p, 16));
      gap  = take_bits(p, 2);
      hold = take_bits(p, 2);
      repeat (gap) begin
        @(negedge clk);
        assert (!ack[p]) else begin
          $display("%0t: c%0d_ack_o high while c%0d_req_i is low", $time, p, p);
          proto_errs++;
        end
      end
      ix  = a[INDEX_W-1:0];
      hit = (o == OP_LOAD) && mvalid[p][ix] && (mtag[p][ix] == a[ADDR_W-1:INDEX_W]);
      n0  = i_mem_responder.src_cnt[src];
      if (o == OP_STORE) begin
        st_pend[p] = 1'b1;
        st_addr[p] = a;
        st_data[p] = d;
        if (ld_open[q] && ld_addr[q] == a) begin
          add_ok(q, d);
        end
      end else if (!hit) begin
        ld_open[p] = 1'b1;
        ld_addr[p] = a;
        ok_n[p]    = 0;
        add_ok(p, mmem[a]);
        if (st_pend[q] && st_addr[q] == a) begin
          add_ok(p, st_data[q]);
        end
      end
      req[p]    = 1'b1;
      op_sel[p] = o;
      addr[p]   = a;
      wdata[p]  = d;
      stored    = 1'b0;
      cyc = 0;
      do begin
        @(negedge clk);
        cyc++;
        // model memory takes stores in the order they reach the memory link
        if (o == OP_STORE && !stored && i_mem_responder.src_cnt[src] != n0) begin
          mmem[a] = d;
          stored  = 1'b1;
        end
      end while (!ack[p]);
      got = rdata[p];
      repeat (hold) begin
        @(negedge clk);
        assert (ack[p]) else begin
          $display("%0t: c%0d_ack_o fell while c%0d_req_i was still high", $time, p, p);
          proto_errs++;
        end
      end
      req[p] = 1'b0;
      dn = i_mem_responder.src_cnt[src] - n0;
      assert (dn == (hit ? 0 : 1)) else begin
        $display("%0t: port %0d saw %0d memory transactions for a %s %s, expected %0d",
                 $time, p, dn, hit ? "hit" : "miss", o.name(), hit ? 0 : 1);
        proto_errs++;
      end
      if (!hit) begin
        assert (i_mem_responder.last_addr[src] == a) else begin
          $display("Mismatch at %0t: mem_addr_o = %h, expected %h",
                   $time, i_mem_responder.last_addr[src], a);
          data_errs++;
        end
        assert (i_mem_responder.last_op[src] == o) else begin
          $display("Mismatch at %0t: mem_op_o = %0d, expected %0d",
                   $time, i_mem_responder.last_op[src], o);
          data_errs++;
        end
      end
      if (o == OP_STORE) begin
        assert (i_mem_responder.last_wdata[src] == d) else begin
          $display("Mismatch at %0t: mem_wdata_o = %h, expected %h",
                   $time, i_mem_responder.last_wdata[src], d);
          data_errs++;
        end
        st_pend[p] = 1'b0;
        mdata[p][ix] = d;
      end else if (hit) begin
        assert (cyc == 2) else begin
          $display("%0t: port %0d load hit acked after %0d cycles, expected 2", $time, p, cyc);
          proto_errs++;
        end
        assert (got == mdata[p][ix]) else begin
          $display("Mismatch at %0t: c%0d_rdata_o = %h, expected %h",
                   $time, p, got, mdata[p][ix]);
          data_errs++;
        end
      end else begin
        assert (is_ok(p, got)) else begin
          $display("Mismatch at %0t: c%0d_rdata_o = %h, expected %h",
                   $time, p, got, ok_vals[p][0]);
          data_errs++;
        end
        mdata[p][ix] = is_ok(p, got) ? got : ok_vals[p][0];
        ld_open[p]   = 1'b0;
      end
      mvalid[p][ix] = 1'b1;
      mtag[p][ix]   = a[ADDR_W-1:INDEX_W];
      @(negedge clk);
      assert (!ack[p]) else begin
        $display("%0t: c%0d_ack_o did not fall one cycle after c%0d_req_i fell", $time, p, p);
        proto_errs++;
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    mem_delay = 2'(take_bits(2, 2));
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout: run still busy after %0d cycles", TIMEOUT);
      timed_out = 1'b1;
      report();
    end
  end

  initial begin
    lfsr_s[0] = SEED;
    lfsr_s[1] = SEED ^ 32'h9e37_79b9;
    lfsr_s[2] = SEED ^ 32'h3c6e_f372;
    data_errs   = 0;
    proto_errs  = 0;
    cycles      = 0;
    timed_out   = 1'b0;
    mem_delay   = 2'd0;
    arst_n      = 1'b0;
    global_x_in = BASE_X;
    req         = '0;
    op_sel      = '0;
    addr        = '0;
    wdata       = '0;
    for (int a = 0; a < 2**ADDR_W; a++) begin
      mmem[a] = {a[7:0], a[7:0] ^ 8'ha5};
    end
    for (int p = 0; p < 2; p++) begin
      st_pend[p] = 1'b0;
      ld_open[p] = 1'b0;
      ok_n[p]    = 0;
      for (int s = 0; s < SETS; s++) begin
        mvalid[p][s] = 1'b0;
      end
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    repeat (2) @(negedge clk);
    assert (global_x_out == BASE_X + 2'd2) else begin
      $display("Mismatch at %0t: global_x_o = %0d, expected %0d",
               $time, global_x_out, BASE_X + 2'd2);
      data_errs++;
    end
    fork
      run_port(0);
      run_port(1);
    join
    assert (i_mem_responder.txn_cnt == i_mem_responder.src_cnt[BASE_X]
            + i_mem_responder.src_cnt[BASE_X + 1'b1]) else begin
      $display("%0t: memory transactions carried an unknown mem_src_o", $time);
      proto_errs++;
    end
    for (int a = 0; a < 2**ADDR_W; a++) begin
      assert (i_mem_responder.mem[a] == mmem[a]) else begin
        $display("Mismatch at %0t: mem[%h] = %h, expected %h",
                 $time, a[7:0], i_mem_responder.mem[a], mmem[a]);
        data_errs++;
      end
    end
    report();
  end

endmodule

/* tests/vcache_mem_responder.sv */
module vcache_mem_responder
  import vcache_pkg::*;
(
  input  logic              clk_i
  , input  logic              mem_req_i
  , input  vcache_op_e        mem_op_i
  , input  logic [ADDR_W-1:0] mem_addr_i
  , input  logic [DATA_W-1:0] mem_wdata_i
  , input  logic [X_W-1:0]    mem_src_i
  , input  logic [1:0]        delay_i
  , output logic              mem_ack_o
  , output logic [DATA_W-1:0] mem_rdata_o
  , output int                error_cnt_o
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  // per source coordinate log of the last transaction
  int                src_cnt    [2**X_W];
  vcache_op_e        last_op    [2**X_W];
  logic [ADDR_W-1:0] last_addr  [2**X_W];
  logic [DATA_W-1:0] last_wdata [2**X_W];
  int                txn_cnt;

  logic open_q;
  logic req_q;
  int   wait_n;

  initial begin
    for (int a = 0; a < 2**ADDR_W; a++) begin
      mem[a] = {a[7:0], a[7:0] ^ 8'ha5};
    end
    for (int s = 0; s < 2**X_W; s++) begin
      src_cnt[s] = 0;
    end
    txn_cnt     = 0;
    error_cnt_o = 0;
    mem_ack_o   = 1'b0;
    mem_rdata_o = '0;
    open_q      = 1'b0;
    req_q       = 1'b0;
    wait_n      = 0;
  end

  always @(negedge clk_i) begin
    if (mem_req_i && !req_q) begin
      assert (!open_q) else begin
        $display("%0t: mem_req_o rose while a memory transaction was still open", $time);
        error_cnt_o++;
      end
      open_q                = 1'b1;
      wait_n                = delay_i;
      txn_cnt++;
      src_cnt[mem_src_i]++;
      last_op[mem_src_i]    = mem_op_i;
      last_addr[mem_src_i]  = mem_addr_i;
      last_wdata[mem_src_i] = mem_wdata_i;
    end
    if (open_q && mem_req_i && !mem_ack_o) begin
      if (wait_n == 0) begin
        if (mem_op_i == OP_STORE) begin
          mem[mem_addr_i] = mem_wdata_i;
        end
        mem_rdata_o = mem[mem_addr_i];
        mem_ack_o   = 1'b1;
      end else begin
        wait_n--;
      end
    end else if (mem_ack_o && !mem_req_i) begin
      mem_ack_o = 1'b0;
      open_q    = 1'b0;
    end
    req_q = mem_req_i;
  end

endmodule

/* hdl/vcache_array.sv */
module vcache_array
  import vcache_pkg::*;
(
  input  logic              clk_i
  , input  logic              arst_n_i

  , input  logic [X_W-1:0]    global_x_i
  , output logic [X_W-1:0]    global_x_o

  // core port 0
  , input  logic              c0_req_i
  , input  vcache_op_e        c0_op_i
  , input  logic [ADDR_W-1:0] c0_addr_i
  , input  logic [DATA_W-1:0] c0_wdata_i
  , output logic              c0_ack_o
  , output logic [DATA_W-1:0] c0_rdata_o

  // core port 1
  , input  logic              c1_req_i
  , input  vcache_op_e        c1_op_i
  , input  logic [ADDR_W-1:0] c1_addr_i
  , input  logic [DATA_W-1:0] c1_wdata_i
  , output logic              c1_ack_o
  , output logic [DATA_W-1:0] c1_rdata_o

  // memory link
  , output logic              mem_req_o
  , output vcache_op_e        mem_op_o
  , output logic [ADDR_W-1:0] mem_addr_o
  , output logic [DATA_W-1:0] mem_wdata_o
  , output logic [X_W-1:0]    mem_src_o
  , input  logic              mem_ack_i
  , input  logic [DATA_W-1:0] mem_rdata_i
);

  // coordinate chain between the tiles
  logic [X_W-1:0] x_01;

  logic              t0_req, t1_req;
  vcache_op_e        t0_op, t1_op;
  logic [ADDR_W-1:0] t0_addr, t1_addr;
  logic [DATA_W-1:0] t0_wdata, t1_wdata;
  logic [X_W-1:0]    t0_src, t1_src;
  logic              t0_ack, t1_ack;
  logic [DATA_W-1:0] t0_rdata, t1_rdata;

  vcache_tile i_tile_0 (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.global_x_i(global_x_i)
    ,.global_x_o(x_01)
    ,.req_i(c0_req_i)
    ,.op_i(c0_op_i)
    ,.addr_i(c0_addr_i)
    ,.wdata_i(c0_wdata_i)
    ,.ack_o(c0_ack_o)
    ,.rdata_o(c0_rdata_o)
    ,.dma_req_o(t0_req)
    ,.dma_op_o(t0_op)
    ,.dma_addr_o(t0_addr)
    ,.dma_wdata_o(t0_wdata)
    ,.dma_src_o(t0_src)
    ,.dma_ack_i(t0_ack)
    ,.dma_rdata_i(t0_rdata)
  );

  vcache_tile i_tile_1 (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.global_x_i(x_01)
    ,.global_x_o(global_x_o)
    ,.req_i(c1_req_i)
    ,.op_i(c1_op_i)
    ,.addr_i(c1_addr_i)
    ,.wdata_i(c1_wdata_i)
    ,.ack_o(c1_ack_o)
    ,.rdata_o(c1_rdata_o)
    ,.dma_req_o(t1_req)
    ,.dma_op_o(t1_op)
    ,.dma_addr_o(t1_addr)
    ,.dma_wdata_o(t1_wdata)
    ,.dma_src_o(t1_src)
    ,.dma_ack_i(t1_ack)
    ,.dma_rdata_i(t1_rdata)
  );

  vcache_dma_arbiter i_arbiter (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.t0_req_i(t0_req)
    ,.t0_op_i(t0_op)
    ,.t0_addr_i(t0_addr)
    ,.t0_wdata_i(t0_wdata)
    ,.t0_src_i(t0_src)
    ,.t0_ack_o(t0_ack)
    ,.t0_rdata_o(t0_rdata)
    ,.t1_req_i(t1_req)
    ,.t1_op_i(t1_op)
    ,.t1_addr_i(t1_addr)
    ,.t1_wdata_i(t1_wdata)
    ,.t1_src_i(t1_src)
    ,.t1_ack_o(t1_ack)
    ,.t1_rdata_o(t1_rdata)
    ,.mem_req_o(mem_req_o)
    ,.mem_op_o(mem_op_o)
    ,.mem_addr_o(mem_addr_o)
    ,.mem_wdata_o(mem_wdata_o)
    ,.mem_src_o(mem_src_o)
    ,.mem_ack_i(mem_ack_i)
    ,.mem_rdata_i(mem_rdata_i)
  );

endmodule

/* hdl/vcache_dma_arbiter.sv */
module vcache_dma_arbiter
  import vcache_pkg::*;
(
  input  logic              clk_i
  , input  logic              arst_n_i

  // tile 0
  , input  logic              t0_req_i
  , input  vcache_op_e        t0_op_i
  , input  logic [ADDR_W-1:0] t0_addr_i
  , input  logic [DATA_W-1:0] t0_wdata_i
  , input  logic [X_W-1:0]    t0_src_i
  , output logic              t0_ack_o
  , output logic [DATA_W-1:0] t0_rdata_o

  // tile 1
  , input  logic              t1_req_i
  , input  vcache_op_e        t1_op_i
  , input  logic [ADDR_W-1:0] t1_addr_i
  , input  logic [DATA_W-1:0] t1_wdata_i
  , input  logic [X_W-1:0]    t1_src_i
  , output logic              t1_ack_o
  , output logic [DATA_W-1:0] t1_rdata_o

  // memory link
  , output logic              mem_req_o
  , output vcache_op_e        mem_op_o
  , output logic [ADDR_W-1:0] mem_addr_o
  , output logic [DATA_W-1:0] mem_wdata_o
  , output logic [X_W-1:0]    mem_src_o
  , input  logic              mem_ack_i
  , input  logic [DATA_W-1:0] mem_rdata_i
);

  logic busy_q, owner_q, prio_q, ack_seen_q;
  logic t0_ack_q, t1_ack_q;
  logic gnt0, gnt1;
  logic own_req;

  // prio_q names the tile that wins a tie
  assign gnt0 = !busy_q && t0_req_i && (!t1_req_i || !prio_q);
  assign gnt1 = !busy_q && t1_req_i && !gnt0;

  assign own_req = owner_q ? t1_req_i : t0_req_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q     <= 1'b0;
      owner_q    <= 1'b0;
      prio_q     <= 1'b0;
      ack_seen_q <= 1'b0;
      mem_req_o  <= 1'b0;
      t0_ack_q   <= 1'b0;
      t1_ack_q   <= 1'b0;
    end else begin
      mem_req_o <= busy_q && own_req;
      t0_ack_q  <= busy_q && !owner_q && mem_ack_i;
      t1_ack_q  <= busy_q && owner_q && mem_ack_i;
      if (gnt0 || gnt1) begin
        busy_q  <= 1'b1;
        owner_q <= gnt1;
        prio_q  <= !gnt1;
      end else if (busy_q) begin
        if (mem_ack_i) begin
          ack_seen_q <= 1'b1;
        end else if (ack_seen_q) begin
          // memory side has released
          busy_q     <= 1'b0;
          ack_seen_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (busy_q) begin
      mem_op_o    <= owner_q ? t1_op_i : t0_op_i;
      mem_addr_o  <= owner_q ? t1_addr_i : t0_addr_i;
      mem_wdata_o <= owner_q ? t1_wdata_i : t0_wdata_i;
      mem_src_o   <= owner_q ? t1_src_i : t0_src_i;
      if (mem_ack_i && !owner_q) begin
        t0_rdata_o <= mem_rdata_i;
      end
      if (mem_ack_i && owner_q) begin
        t1_rdata_o <= mem_rdata_i;
      end
    end
  end

  assign t0_ack_o = t0_ack_q;
  assign t1_ack_o = t1_ack_q;

endmodule

/* hdl/vcache_tile.sv */
module vcache_tile
  import vcache_pkg::*;
(
  input  logic              clk_i
  , input  logic              arst_n_i

  , input  logic [X_W-1:0]    global_x_i
  , output logic [X_W-1:0]    global_x_o

  // core side
  , input  logic              req_i
  , input  vcache_op_e        op_i
  , input  logic [ADDR_W-1:0] addr_i
  , input  logic [DATA_W-1:0] wdata_i
  , output logic              ack_o
  , output logic [DATA_W-1:0] rdata_o

  // dma side
  , output logic              dma_req_o
  , output vcache_op_e        dma_op_o
  , output logic [ADDR_W-1:0] dma_addr_o
  , output logic [DATA_W-1:0] dma_wdata_o
  , output logic [X_W-1:0]    dma_src_o
  , input  logic              dma_ack_i
  , input  logic [DATA_W-1:0] dma_rdata_i
);

  tile_state_e state_q, state_d;

  logic [X_W-1:0] x_q;

  logic [SETS-1:0]   valid_q;
  logic [TAG_W-1:0]  tag_q  [SETS];
  logic [DATA_W-1:0] data_q [SETS];

  vcache_op_e        op_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [DATA_W-1:0] rdata_q;

  logic [INDEX_W-1:0] idx;
  logic [TAG_W-1:0]   tag;
  logic               hit;

  assign idx = addr_q[INDEX_W-1:0];
  assign tag = addr_q[ADDR_W-1:INDEX_W];
  assign hit = valid_q[idx] && (tag_q[idx] == tag);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (req_i) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        // only a load hit skips the memory link
        if (op_q == OP_LOAD && hit) begin
          state_d = ST_ACK;
        end else begin
          state_d = ST_DMA_REQ;
        end
      end
      ST_DMA_REQ: begin
        if (dma_ack_i) begin
          state_d = ST_DMA_WAIT;
        end
      end
      ST_DMA_WAIT: begin
        if (!dma_ack_i) begin
          state_d = ST_DMA_DONE;
        end
      end
      ST_DMA_DONE: begin
        state_d = ST_ACK;
      end
      ST_ACK: begin
        if (!req_i) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      x_q     <= '0;
      valid_q <= '0;
    end else begin
      state_q <= state_d;
      x_q     <= global_x_i;
      if (state_q == ST_DMA_DONE) begin
        valid_q[idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && req_i) begin
      op_q    <= op_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (state_q == ST_LOOKUP) begin
      rdata_q <= data_q[idx];
    end
    // stores write through, so the line takes the store data
    if (state_q == ST_DMA_REQ && dma_ack_i) begin
      rdata_q <= (op_q == OP_STORE) ? wdata_q : dma_rdata_i;
    end
    if (state_q == ST_DMA_DONE) begin
      tag_q[idx]  <= tag;
      data_q[idx] <= rdata_q;
    end
  end

  assign ack_o   = (state_q == ST_ACK);
  assign rdata_o = rdata_q;

  assign dma_req_o   = (state_q == ST_DMA_REQ);
  assign dma_op_o    = op_q;
  assign dma_addr_o  = addr_q;
  assign dma_wdata_o = wdata_q;
  assign dma_src_o   = x_q;

  // neighbor sits one column east
  assign global_x_o = x_q + 1'b1;

endmodule

/* hdl/vcache_pkg.sv */
package vcache_pkg;

  // word address and data widths
  localparam int ADDR_W = 8;
  localparam int DATA_W = 16;

  // direct mapped, one word per line
  localparam int SETS    = 8;
  localparam int INDEX_W = 3;
  localparam int TAG_W   = ADDR_W - INDEX_W;

  // tile x coordinate
  localparam int X_W = 4;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } vcache_op_e;

  // tile controller
  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,
    ST_LOOKUP   = 3'd1,
    ST_DMA_REQ  = 3'd2,
    ST_DMA_WAIT = 3'd3,
    ST_DMA_DONE = 3'd4,
    ST_ACK      = 3'd5
  } tile_state_e;

endpackage
